// ==== src/video_macros.svh ====
/*
 * Raster constants of the video path.
 * Line and frame size, visible window, sync positions,
 * line buffer depth and the coordinate and pixel widths.
 */
`ifndef VIDEO_MACROS_SVH
`define VIDEO_MACROS_SVH

// widths of the data words.
`define VID_COORD_W 9          // wide enough for 0 to 511.
`define VID_BUF_ADDR_W 9       // index into one half of the buffer.
`define VID_PIXEL_W 8          // colour index.

// horizontal raster, counted in cen8 ticks.
`define VID_H_TOTAL 512        // hdump runs 0 to 511.
`define VID_H_VIS_START 64     // first visible pixel.
`define VID_H_VIS_END 448      // first blanked pixel after the active part.
`define VID_HS_START 'h1DC     // HS goes high after this position.

// vertical raster, counted in lines.
`define VID_V_TOTAL 262
`define VID_V_VIS_START 14     // 224 visible lines, 14 to 237.
`define VID_V_VIS_END 237
`define VID_VS_ON_LINE 'h100   // VS rises with HS on this line.
`define VID_VS_OFF_LINE 'h001  // and falls with HS on this one.

// one line of visible pixels, and the buffer that holds two of them.
`define VID_LINE_PIXELS 384
`define VID_BUF_DEPTH (2 * `VID_LINE_PIXELS)

`endif

// ==== src/videoPkg.sv ====
/*
 * Raster coordinate types and the renderer FSM states.
 */
`include "video_macros.svh"

package videoPkg;

    // a pixel or line counter value.
    // hdump, vdump, vrender and vrender1 all use it.
    typedef logic [`VID_COORD_W-1:0] coordT;

    // address of one word inside one half of the line buffer.
    // Only 0 to 383 are ever used.
    typedef logic [`VID_BUF_ADDR_W-1:0] bufAddrT;

    // the renderer waits in idle for the line start.
    // It spends the first 384 ticks of the line in draw.
    typedef enum logic [0:0] {
        idle,  // nothing to write.
        draw   // one pixel per cen8 tick.
    } renderStateT;

endpackage

// ==== src/pixelPkg.sv ====
/*
 * Pixel type and the test pattern rule.
 * The renderer and the reference model both call patternPixel.
 */
`include "video_macros.svh"

package pixelPkg;

    typedef logic [`VID_PIXEL_W-1:0] pixelT;  // colour index.

    // the pattern is the low byte of x against the low byte of y with its nibbles swapped.
    // Both diagonal stripes and line-to-line changes show up on screen this way.
    function automatic pixelT patternPixel(videoPkg::coordT x, videoPkg::coordT y);
        pixelT swappedY;
        swappedY = {y[3:0], y[7:4]};  // nibble swap of the line byte.
        return x[7:0] ^ swappedY;
    endfunction

endpackage

// ==== src/lineBufIf.sv ====
/*
 * Signals of the ping-pong line buffer.
 * Write port and swap pulse, read port, and the producer,
 * buffer and consumer views of them.
 */
`timescale 1ns/1ps

interface lineBufIf;

    logic              wrEn;    // write strobe, one word per clock.
    videoPkg::bufAddrT wrAddr;  // address in the back half.
    pixelPkg::pixelT   wrData;
    logic              swap;    // one-clock pulse at the line start.
    videoPkg::bufAddrT rdAddr;  // address in the front half.
    pixelPkg::pixelT   rdData;  // valid one clock after rdAddr.

    // the renderer fills the back half and flips the halves.
    modport producer (
        output wrEn,
        output wrAddr,
        output wrData,
        output swap
    );

    // the memory itself.
    modport buffer (
        input  wrEn,
        input  wrAddr,
        input  wrData,
        input  swap,
        input  rdAddr,
        output rdData
    );

    // the scanout only reads.
    modport consumer (
        output rdAddr,
        input  rdData
    );

endinterface

// ==== src/videoTiming.sv ====
/*
 * Pixel and line counters of the raster.
 * HS, VS, HB, VB and preVB generation, the line start strobe,
 * and the look-ahead line counters vrender and vrender1.
 */
`timescale 1ns/1ps
`include "video_macros.svh"

module videoTiming (
    input  logic            clk,
    input  logic            rstN,
    input  logic            cen8,
    output videoPkg::coordT hdump,     // pixel being shown.
    output videoPkg::coordT vdump,     // line being shown.
    output videoPkg::coordT vrender,   // line being drawn, one ahead of vdump.
    output videoPkg::coordT vrender1,  // two lines ahead of vdump.
    output logic            start,     // high for the first tick of each line.
    output logic            HS,
    output logic            VS,
    output logic            VB,
    output logic            preVB,
    output logic            HB
);

    localparam videoPkg::coordT lastPixel = videoPkg::coordT'(`VID_H_TOTAL - 1);
    localparam videoPkg::coordT lastLine  = videoPkg::coordT'(`VID_V_TOTAL - 1);
    localparam videoPkg::coordT hVisStart = videoPkg::coordT'(`VID_H_VIS_START);
    localparam videoPkg::coordT hVisEnd   = videoPkg::coordT'(`VID_H_VIS_END);
    localparam videoPkg::coordT vVisStart = videoPkg::coordT'(`VID_V_VIS_START);
    localparam videoPkg::coordT vVisEnd   = videoPkg::coordT'(`VID_V_VIS_END);
    localparam videoPkg::coordT hsStart   = videoPkg::coordT'(`VID_HS_START);
    localparam videoPkg::coordT vsOnLine  = videoPkg::coordT'(`VID_VS_ON_LINE);
    localparam videoPkg::coordT vsOffLine = videoPkg::coordT'(`VID_VS_OFF_LINE);

    logic [1:0] shVB;  // vertical blank shift, one stage per line.

    assign preVB = shVB[0];  // VB as it will look two lines from now.

    always_ff @(posedge clk) begin
        if (!rstN) begin
            hdump    <= '0;
            vdump    <= '0;
            vrender  <= videoPkg::coordT'(1);
            vrender1 <= videoPkg::coordT'(2);
            HB       <= 1'b1;
            VB       <= 1'b1;
            shVB     <= 2'b11;
            HS       <= 1'b0;
            VS       <= 1'b0;
            start    <= 1'b0;
        end else if (cen8) begin
            hdump   <= hdump + 1'b1;
            shVB[0] <= (vdump < vVisStart) || (vdump > vVisEnd);  // line condition.
            HB      <= (hdump >= hVisEnd) || (hdump < hVisStart);  // one tick behind hdump.
            // HS stays high from 0x1DD to 0, about 36 ticks.
            if (hdump == hsStart) begin
                HS <= 1'b1;
                // VS only moves on the rising edge of HS.
                if (vdump == vsOnLine) VS <= 1'b1;
                if (vdump == vsOffLine) VS <= 1'b0;
            end
            if (hdump == '0) HS <= 1'b0;
            start <= (hdump == lastPixel);  // marks the tick where hdump is back at 0.
            if (hdump == lastPixel) begin
                hdump    <= '0;
                vrender1 <= (vrender1 == lastLine) ? '0 : vrender1 + 1'b1;
                vrender  <= vrender1;  // the look-ahead counters hand down one line.
                vdump    <= vrender;
                {VB, shVB[1]} <= shVB;  // VB ends up two lines behind the condition.
            end
        end
    end

    // the counters never leave the raster.
    assert property (@(posedge clk) disable iff (!rstN) hdump <= lastPixel);
    assert property (@(posedge clk) disable iff (!rstN) vrender1 <= lastLine);

    // start is cleared by the tick that follows it.
    assert property (@(posedge clk) disable iff (!rstN) (start && cen8) |=> !start);

endmodule

// ==== src/lineRenderer.sv ====
/*
 * Producer of the line buffer.
 * Two-state FSM that writes the pattern of line vrender
 * into the back half, one pixel per cen8 tick.
 */
`timescale 1ns/1ps
`include "video_macros.svh"

module lineRenderer (
    input  logic            clk,
    input  logic            rstN,
    input  logic            cen8,
    input  logic            start,    // line start from the timing block.
    input  videoPkg::coordT vrender,  // the line that is shown next.
    lineBufIf.producer      lineBuf
);

    localparam videoPkg::coordT lastX = videoPkg::coordT'(`VID_LINE_PIXELS - 1);

    videoPkg::renderStateT state;
    videoPkg::coordT       x;  // pixel being written.
    videoPkg::coordT       y;  // line being written, held for the whole line.

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= videoPkg::idle;
            x     <= '0;
        end else if (cen8) begin
            case (state)
                videoPkg::idle: begin
                    if (start) begin
                        state <= videoPkg::draw;
                        x     <= '0;  // the first write lands on the next tick.
                    end
                end
                videoPkg::draw: begin
                    x <= x + 1'b1;
                    if (x == lastX) state <= videoPkg::idle;  // 384 words done.
                end
                default: state <= videoPkg::idle;
            endcase
        end
    end

    // y only changes at a line start.
    always_ff @(posedge clk) begin
        if (start && cen8) y <= vrender;
    end

    // the halves flip in the same clock the new line begins.
    // The write that follows goes to the half just freed by the scanout.
    assign lineBuf.swap   = start && cen8;
    assign lineBuf.wrEn   = (state == videoPkg::draw) && cen8;  // one word per tick.
    assign lineBuf.wrAddr = videoPkg::bufAddrT'(x);
    assign lineBuf.wrData = pixelPkg::patternPixel(x, y);

    // writes stay inside one half.
    assert property (@(posedge clk) disable iff (!rstN)
        lineBuf.wrEn |-> (lineBuf.wrAddr <= videoPkg::bufAddrT'(lastX)));

    // a line is fully drawn before the next start arrives.
    assert property (@(posedge clk) disable iff (!rstN)
        (start && cen8) |-> (state == videoPkg::idle));

endmodule

// ==== src/lineBuffer.sv ====
/*
 * Ping-pong line buffer.
 * Two halves of one line each, a bank bit flipped by swap,
 * a write port on the back half and a registered read of the front half.
 */
`timescale 1ns/1ps
`include "video_macros.svh"

module lineBuffer (
    input logic      clk,
    input logic      rstN,
    lineBufIf.buffer lineBuf
);

    localparam int halfDepth = `VID_LINE_PIXELS;
    localparam int depth     = `VID_BUF_DEPTH;

    typedef logic [$clog2(depth)-1:0] memIdxT;  // index into the whole memory.

    pixelPkg::pixelT mem [depth];  // lower half is bank 0, upper half bank 1.
    logic            bank;         // half that is being written.
    memIdxT          wrIdx;
    memIdxT          rdIdx;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            bank <= 1'b0;
        end else if (lineBuf.swap) begin
            bank <= ~bank;  // the freshly drawn half goes on screen.
        end
    end

    // writes go to the half bank selects and reads to the other one.
    always_comb begin
        wrIdx = memIdxT'(lineBuf.wrAddr) + (bank ? memIdxT'(halfDepth) : '0);
        rdIdx = memIdxT'(lineBuf.rdAddr) + (bank ? '0 : memIdxT'(halfDepth));
    end

    always_ff @(posedge clk) begin
        if (lineBuf.wrEn) mem[wrIdx] <= lineBuf.wrData;
        lineBuf.rdData <= mem[rdIdx];  // read every clock, one clock of latency.
    end

    // the bank must not flip under a write.
    // Otherwise the word would land in the half on screen.
    assert property (@(posedge clk) disable iff (!rstN)
        !(lineBuf.swap && lineBuf.wrEn));

endmodule

// ==== src/pixelScanout.sv ====
/*
 * Consumer of the line buffer.
 * Read address from hdump, registered pixel output,
 * black during horizontal and vertical blanking.
 */
`timescale 1ns/1ps
`include "video_macros.svh"

module pixelScanout (
    input  logic            clk,
    input  logic            rstN,
    input  logic            cen8,
    input  videoPkg::coordT hdump,
    input  logic            HB,
    input  logic            VB,
    lineBufIf.consumer      lineBuf,
    output pixelPkg::pixelT pixel
);

    localparam videoPkg::coordT visStart = videoPkg::coordT'(`VID_H_VIS_START);
    localparam videoPkg::coordT visEnd   = videoPkg::coordT'(`VID_H_VIS_END);

    logic inWindow;  // hdump is inside the active part of the line.

    assign inWindow = (hdump >= visStart) && (hdump < visEnd);

    // the address is held for a whole tick.
    // rdData has settled by the next tick however long the gap in cen8.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            lineBuf.rdAddr <= '0;
        end else if (cen8) begin
            // outside the window the address parks at 0 so the read stays in range.
            lineBuf.rdAddr <= inWindow ? videoPkg::bufAddrT'(hdump - visStart) : '0;
        end
    end

    // HB is registered from hdump one tick earlier.
    // By this tick it describes the position whose word is in rdData.
    // VB only moves at hdump 511, where HB already blanks.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            pixel <= '0;
        end else if (cen8) begin
            pixel <= (HB || VB) ? '0 : lineBuf.rdData;
        end
    end

endmodule

// ==== src/videoTop.sv ====
/*
 * Top level of the video path.
 * Timing generator, line renderer, ping-pong buffer and scanout,
 * joined through one line buffer interface.
 */
`timescale 1ns/1ps

module videoTop (
    input  logic            clk,
    input  logic            rstN,
    input  logic            cen8,   // pixel clock enable.
    output videoPkg::coordT hdump,
    output videoPkg::coordT vdump,
    output pixelPkg::pixelT pixel,  // one tick behind hdump and vdump.
    output logic            HS,
    output logic            VS,
    output logic            HB,
    output logic            VB,
    output logic            preVB
);

    logic            start;    // line start strobe.
    videoPkg::coordT vrender;  // line the renderer draws.

    lineBufIf lineBuf ();  // renderer to buffer to scanout.

    videoTiming timing0 (
        .clk      (clk),
        .rstN     (rstN),
        .cen8     (cen8),
        .hdump    (hdump),
        .vdump    (vdump),
        .vrender  (vrender),
        .vrender1 (),  // only the counter chain inside the timing block needs it.
        .start    (start),
        .HS       (HS),
        .VS       (VS),
        .VB       (VB),
        .preVB    (preVB),
        .HB       (HB)
    );

    lineRenderer renderer0 (
        .clk     (clk),
        .rstN    (rstN),
        .cen8    (cen8),
        .start   (start),
        .vrender (vrender),
        .lineBuf (lineBuf.producer)
    );

    lineBuffer buffer0 (
        .clk     (clk),
        .rstN    (rstN),
        .lineBuf (lineBuf.buffer)
    );

    pixelScanout scanout0 (
        .clk     (clk),
        .rstN    (rstN),
        .cen8    (cen8),
        .hdump   (hdump),
        .HB      (HB),
        .VB      (VB),
        .lineBuf (lineBuf.consumer),
        .pixel   (pixel)
    );

endmodule

// ==== bench/tbVideoTop.sv ====
/*
 * Testbench of the video path.
 * Clock, reset and random cen8 stimulus, a reference model of the raster
 * and the pixel stream, an output comparison process and a watchdog.
 */
`timescale 1ns/1ps
`include "video_macros.svh"

module tbVideoTop;

    localparam int clkPeriod     = 100;  // ns.
    localparam int resetCycles   = 2;
    localparam int frameTicks    = `VID_H_TOTAL * `VID_V_TOTAL;
    localparam int testTicks     = 2 * frameTicks;  // two full frames.
    localparam int clocksPerTick = 4;  // the random enable averages three clocks per tick.
    localparam int watchdogNs    = (testTicks * clocksPerTick + resetCycles + 1000) * clkPeriod;

    localparam videoPkg::coordT lastPixel = videoPkg::coordT'(`VID_H_TOTAL - 1);
    localparam videoPkg::coordT lastLine  = videoPkg::coordT'(`VID_V_TOTAL - 1);
    localparam videoPkg::coordT hVisStart = videoPkg::coordT'(`VID_H_VIS_START);
    localparam videoPkg::coordT hVisEnd   = videoPkg::coordT'(`VID_H_VIS_END);
    localparam videoPkg::coordT vVisStart = videoPkg::coordT'(`VID_V_VIS_START);
    localparam videoPkg::coordT vVisEnd   = videoPkg::coordT'(`VID_V_VIS_END);
    localparam videoPkg::coordT hsStart   = videoPkg::coordT'(`VID_HS_START);
    localparam videoPkg::coordT vsOnLine  = videoPkg::coordT'(`VID_VS_ON_LINE);
    localparam videoPkg::coordT vsOffLine = videoPkg::coordT'(`VID_VS_OFF_LINE);

    logic            clk;
    logic            rstN;
    logic            cen8;
    videoPkg::coordT hdump;
    videoPkg::coordT vdump;
    pixelPkg::pixelT pixel;
    logic            HS;
    logic            VS;
    logic            HB;
    logic            VB;
    logic            preVB;

    integer seed;  // state of the $random sequence.

    // model of the raster, as it should look after the last clock edge.
    videoPkg::coordT mH;
    videoPkg::coordT mV;
    videoPkg::coordT mVr;     // line one ahead of mV.
    videoPkg::coordT mVr1;    // line two ahead of mV.
    logic            mHB;
    logic            mVB;
    logic            mSh0;    // line blank condition of the current line.
    logic            mSh1;    // the same condition one line older.
    logic            mHS;
    logic            mVS;
    pixelPkg::pixelT mPix;
    videoPkg::coordT lastH;   // position seen on the previous tick.
    videoPkg::coordT lastV;

    videoTop dut0 (
        .clk   (clk),
        .rstN  (rstN),
        .cen8  (cen8),
        .hdump (hdump),
        .vdump (vdump),
        .pixel (pixel),
        .HS    (HS),
        .VS    (VS),
        .HB    (HB),
        .VB    (VB),
        .preVB (preVB)
    );

    initial begin : clockGen
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // all inputs move on the falling edge, half a period away from the sampling edge.
    initial begin : stimulus
        integer rnd;
        rstN = 1'b0;
        cen8 = 1'b0;
        seed = 32'he6087ed3;
        repeat (resetCycles) @(posedge clk);  // reset is seen by this many rising edges.
        @(negedge clk);
        rstN = 1'b1;
        forever begin
            // a tick is followed by at least one idle clock.
            // A pixel enable divided from a faster clock behaves the same way.
            if (cen8) begin
                cen8 = 1'b0;
            end else begin
                rnd  = $random(seed);
                cen8 = rnd[0];  // high about half of the remaining clocks.
            end
            @(negedge clk);
        end
    end

    // pixel expected one tick after the position h, v with the blank flags that go with it.
    function automatic pixelPkg::pixelT expectedPixel(videoPkg::coordT h, videoPkg::coordT v,
                                                      logic hb, logic vb);
        pixelPkg::pixelT result;
        if (hb || vb) begin
            result = '0;  // black during blanking.
        end else begin
            result = pixelPkg::patternPixel(videoPkg::coordT'(h - hVisStart), v);
        end
        return result;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("** Error: %s expected 0x%0h actual 0x%0h at %0t ns",
                     name, expected, actual, $time);
            $display("TEST RESULT: FAIL");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic resetModel();
        mH    = '0;
        mV    = '0;
        mVr   = videoPkg::coordT'(1);
        mVr1  = videoPkg::coordT'(2);
        mHB   = 1'b1;
        mVB   = 1'b1;
        mSh0  = 1'b1;
        mSh1  = 1'b1;
        mHS   = 1'b0;
        mVS   = 1'b0;
        mPix  = '0;
        lastH = '0;
        lastV = '0;
    endtask

    // one cen8 tick of the raster rules, from the values before the edge.
    task automatic advanceModel();
        videoPkg::coordT oldH;
        videoPkg::coordT oldV;
        oldH  = mH;
        oldV  = mV;
        mPix  = expectedPixel(lastH, lastV, mHB, mVB);  // the word read on the last tick.
        lastH = oldH;
        lastV = oldV;
        mHB   = (oldH < hVisStart) || (oldH >= hVisEnd);
        if (oldH == hsStart) begin
            mHS = 1'b1;
            if (oldV == vsOnLine) mVS = 1'b1;  // VS only moves with the HS rise.
            if (oldV == vsOffLine) mVS = 1'b0;
        end
        if (oldH == '0) mHS = 1'b0;
        if (oldH == lastPixel) begin
            mH   = '0;
            mV   = mVr;
            mVr  = mVr1;
            mVr1 = (mVr1 == lastLine) ? '0 : mVr1 + 1'b1;
            mVB  = mSh1;  // two lines behind the line condition.
            mSh1 = mSh0;
        end else begin
            mH = oldH + 1'b1;
        end
        mSh0 = (oldV < vVisStart) || (oldV > vVisEnd);
    endtask

    task automatic compareOutputs(input string phase);
        checkValue({phase, " hdump"}, 32'(mH), 32'(hdump));
        checkValue({phase, " vdump"}, 32'(mV), 32'(vdump));
        checkValue({phase, " HB"}, 32'(mHB), 32'(HB));
        checkValue({phase, " VB"}, 32'(mVB), 32'(VB));
        checkValue({phase, " preVB"}, 32'(mSh0), 32'(preVB));
        checkValue({phase, " HS"}, 32'(mHS), 32'(HS));
        checkValue({phase, " VS"}, 32'(mVS), 32'(VS));
        checkValue({phase, " pixel"}, 32'(mPix), 32'(pixel));
    endtask

    // cen8 and rstN are sampled at the rising edge, outputs half a period later.
    initial begin : outputCompare
        int   ticks;
        logic tickNow;
        logic inReset;
        ticks = 0;
        resetModel();
        while (ticks < testTicks) begin
            @(posedge clk);
            tickNow = cen8;
            inReset = !rstN;
            @(negedge clk);
            if (inReset) begin
                resetModel();
                compareOutputs("reset");
            end else if (tickNow) begin
                advanceModel();
                ticks = ticks + 1;
                compareOutputs("tick");
            end else begin
                compareOutputs("idle clock");  // nothing may move without cen8.
            end
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

    initial begin : watchdog
        #(watchdogNs);
        $display("The run timed out after %0d ns before two frames were checked.", watchdogNs);
        $display("TEST RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== tb.f ====
+incdir+src
src/videoPkg.sv
src/pixelPkg.sv
src/lineBufIf.sv
src/videoTiming.sv
src/lineRenderer.sv
src/lineBuffer.sv
src/pixelScanout.sv
src/videoTop.sv
bench/tbVideoTop.sv

// ==== Makefile ====
# Verilator build of the video path testbench.

VERILATOR  ?= verilator
TOP        := tbVideoTop
FILELIST   := tb.f
BUILD_DIR  := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
